//--- verilog/scratchpad_config.svh
// Word and depth settings shared by all files; depth must equal 2**SCRATCHPAD_ADDR_WIDTH
`ifndef SCRATCHPAD_CONFIG_SVH
`define SCRATCHPAD_CONFIG_SVH

// Word width in bits, no byte lanes
`define SCRATCHPAD_DATA_WIDTH 32

// Number of words in the scratchpad
`define SCRATCHPAD_DEPTH 256

// Word address width, log2 of the depth
`define SCRATCHPAD_ADDR_WIDTH 8

// Reads forward a same-cycle write from the other port
// 0 returns the old memory word instead
`define SCRATCHPAD_WRITE_THROUGH 1

`endif

//--- verilog/scratchpad_pkg.sv
// Types take their widths from the config header; owner_t only covers two masters
`default_nettype none

package scratchpad_pkg;

  `include "scratchpad_config.svh"

  // One memory word, the only payload on every bus
  typedef logic [`SCRATCHPAD_DATA_WIDTH-1:0] word_t;

  // Word address, no byte offset bits
  typedef logic [`SCRATCHPAD_ADDR_WIDTH-1:0] addr_t;

  // Arbiter grant holder
  // M0 is master b, M1 is master c at the top level
  typedef enum logic {
    OWNER_M0 = 1'b0,
    OWNER_M1 = 1'b1
  } owner_t;

endpackage : scratchpad_pkg

`default_nettype wire

//--- verilog/true_dual_port_ram.sv
// Same-edge writes to one address keep port 1 data; DEPTH must fit in addr_t; no reset of contents
`timescale 1ns/1ps
`default_nettype none

module true_dual_port_ram #(
  parameter int WIDTH           = 32,
  parameter int DEPTH           = 256,
  parameter bit WRITE_THROUGH   = 1'b1,
  parameter bit REGISTERED_READ = 1'b1
) (
  input  logic                  clock,
  // Port 0
  input  logic                  port_0_access_enable,
  input  logic                  port_0_write,
  input  scratchpad_pkg::addr_t port_0_address,
  input  scratchpad_pkg::word_t port_0_write_data,
  output scratchpad_pkg::word_t port_0_read_data,
  // Port 1
  input  logic                  port_1_access_enable,
  input  logic                  port_1_write,
  input  scratchpad_pkg::addr_t port_1_address,
  input  scratchpad_pkg::word_t port_1_write_data,
  output scratchpad_pkg::word_t port_1_read_data
);

  // Storage
  logic [WIDTH-1:0] memory [DEPTH];

  // Per-port access decode
  logic port_0_write_enable;
  logic port_0_read_enable;
  logic port_1_write_enable;
  logic port_1_read_enable;
  logic same_address;

  // Forwarded or stored word seen by each port this cycle
  scratchpad_pkg::word_t port_0_next_data;
  scratchpad_pkg::word_t port_1_next_data;

  assign port_0_write_enable = port_0_access_enable & port_0_write;
  assign port_0_read_enable  = port_0_access_enable & ~port_0_write;
  assign port_1_write_enable = port_1_access_enable & port_1_write;
  assign port_1_read_enable  = port_1_access_enable & ~port_1_write;
  assign same_address        = port_0_address == port_1_address;

  // Port 1 last, so it wins a same-address collision
  always_ff @(posedge clock) begin
    if (port_0_write_enable) begin
      memory[port_0_address] <= port_0_write_data;
    end
    if (port_1_write_enable) begin
      memory[port_1_address] <= port_1_write_data;
    end
  end

  // Other port's write takes priority over own write
  always_comb begin
    if (WRITE_THROUGH && port_1_write_enable && same_address) begin
      port_0_next_data = port_1_write_data;
    end else if (WRITE_THROUGH && port_0_write_enable) begin
      port_0_next_data = port_0_write_data;
    end else begin
      port_0_next_data = memory[port_0_address];
    end
    if (WRITE_THROUGH && port_0_write_enable && same_address && !port_1_write_enable) begin
      port_1_next_data = port_0_write_data;
    end else if (WRITE_THROUGH && port_1_write_enable) begin
      port_1_next_data = port_1_write_data;
    end else begin
      port_1_next_data = memory[port_1_address];
    end
  end

  if (REGISTERED_READ) begin : g_registered_read
    scratchpad_pkg::word_t port_0_read_q;
    scratchpad_pkg::word_t port_1_read_q;
    // Output holds its last word between reads
    always_ff @(posedge clock) begin
      if (port_0_read_enable) begin
        port_0_read_q <= port_0_next_data;
      end
      if (port_1_read_enable) begin
        port_1_read_q <= port_1_next_data;
      end
    end
    assign port_0_read_data = port_0_read_q;
    assign port_1_read_data = port_1_read_q;
  end else begin : g_combinational_read
    assign port_0_read_data = port_0_next_data;
    assign port_1_read_data = port_1_next_data;
  end

endmodule : true_dual_port_ram

`default_nettype wire

//--- verilog/wb_ram_port.sv
// Wishbone classic slave, single words only; no sel, cti/bte, err or rty; ack one cycle after request
`timescale 1ns/1ps
`default_nettype none

module wb_ram_port (
  input  logic                  clock,
  input  logic                  rst,
  // Wishbone slave side
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  scratchpad_pkg::addr_t adr,
  input  scratchpad_pkg::word_t dat_w,
  output scratchpad_pkg::word_t dat_r,
  output logic                  ack,
  // RAM port side
  output logic                  ram_access_enable,
  output logic                  ram_write,
  output scratchpad_pkg::addr_t ram_address,
  output scratchpad_pkg::word_t ram_write_data,
  input  scratchpad_pkg::word_t ram_read_data
);

  // New request this cycle
  logic request;

  // Master still holds the old request during the ack cycle
  // so masking with ack keeps it to a single RAM access
  assign request = cyc & stb & ~ack;

  // RAM access happens at the same edge that samples the request
  assign ram_access_enable = request;
  assign ram_write         = we;
  assign ram_address       = adr;
  assign ram_write_data    = dat_w;

  // Registered RAM read lands in the ack cycle
  // Combinational read also holds, the address is stable until ack
  assign dat_r = ram_read_data;

  // One-cycle ack pulse
  always_ff @(posedge clock) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= request;
    end
  end

endmodule : wb_ram_port

`default_nettype wire

//--- verilog/wb_round_robin_arbiter.sv
// Two Wishbone classic masters onto one slave; grant held until owner drops cyc; no grant switch per beat
`timescale 1ns/1ps
`default_nettype none

module wb_round_robin_arbiter (
  input  logic                  clock,
  input  logic                  rst,
  // Master 0
  input  logic                  m0_cyc,
  input  logic                  m0_stb,
  input  logic                  m0_we,
  input  scratchpad_pkg::addr_t m0_adr,
  input  scratchpad_pkg::word_t m0_dat_w,
  output scratchpad_pkg::word_t m0_dat_r,
  output logic                  m0_ack,
  // Master 1
  input  logic                  m1_cyc,
  input  logic                  m1_stb,
  input  logic                  m1_we,
  input  scratchpad_pkg::addr_t m1_adr,
  input  scratchpad_pkg::word_t m1_dat_w,
  output scratchpad_pkg::word_t m1_dat_r,
  output logic                  m1_ack,
  // Slave side
  output logic                  s_cyc,
  output logic                  s_stb,
  output logic                  s_we,
  output scratchpad_pkg::addr_t s_adr,
  output scratchpad_pkg::word_t s_dat_w,
  input  scratchpad_pkg::word_t s_dat_r,
  input  logic                  s_ack
);

  // Grant state
  logic                   busy;
  scratchpad_pkg::owner_t owner;
  scratchpad_pkg::owner_t last_served;

  // Winner if granting this edge
  scratchpad_pkg::owner_t next_owner;

  // Cycle line of the current owner
  logic owner_cyc;

  // Tie goes to the master not served last
  always_comb begin
    if (m0_cyc && m1_cyc) begin
      next_owner = (last_served == scratchpad_pkg::OWNER_M1) ?
                   scratchpad_pkg::OWNER_M0 : scratchpad_pkg::OWNER_M1;
    end else if (m1_cyc) begin
      next_owner = scratchpad_pkg::OWNER_M1;
    end else begin
      next_owner = scratchpad_pkg::OWNER_M0;
    end
  end

  assign owner_cyc = (owner == scratchpad_pkg::OWNER_M1) ? m1_cyc : m0_cyc;

  // Grant on any cyc while idle, release when owner drops cyc
  // Release and new grant take separate edges
  always_ff @(posedge clock) begin
    if (rst) begin
      busy        <= 1'b0;
      owner       <= scratchpad_pkg::OWNER_M0;
      last_served <= scratchpad_pkg::OWNER_M1;
    end else if (!busy) begin
      if (m0_cyc || m1_cyc) begin
        busy        <= 1'b1;
        owner       <= next_owner;
        last_served <= next_owner;
      end
    end else if (!owner_cyc) begin
      busy <= 1'b0;
    end
  end

  // Forward owner request, nothing reaches the slave while idle
  always_comb begin
    if (owner == scratchpad_pkg::OWNER_M1) begin
      s_cyc   = busy & m1_cyc;
      s_stb   = busy & m1_stb;
      s_we    = m1_we;
      s_adr   = m1_adr;
      s_dat_w = m1_dat_w;
    end else begin
      s_cyc   = busy & m0_cyc;
      s_stb   = busy & m0_stb;
      s_we    = m0_we;
      s_adr   = m0_adr;
      s_dat_w = m0_dat_w;
    end
  end

  // Response only to the owner, the loser sees zeros
  always_comb begin
    m0_ack   = 1'b0;
    m1_ack   = 1'b0;
    m0_dat_r = '0;
    m1_dat_r = '0;
    if (busy && owner == scratchpad_pkg::OWNER_M0) begin
      m0_ack   = s_ack;
      m0_dat_r = s_dat_r;
    end
    if (busy && owner == scratchpad_pkg::OWNER_M1) begin
      m1_ack   = s_ack;
      m1_dat_r = s_dat_r;
    end
  end

endmodule : wb_round_robin_arbiter

`default_nettype wire

//--- verilog/shared_scratchpad.sv
// Three Wishbone classic masters on one dual-port RAM; port a fixed latency, b and c arbitrated
`timescale 1ns/1ps
`default_nettype none

`include "scratchpad_config.svh"

module shared_scratchpad (
  input  logic                  clock,
  input  logic                  rst,
  // Master a, host on RAM port 0
  input  logic                  a_cyc,
  input  logic                  a_stb,
  input  logic                  a_we,
  input  scratchpad_pkg::addr_t a_adr,
  input  scratchpad_pkg::word_t a_dat_w,
  output scratchpad_pkg::word_t a_dat_r,
  output logic                  a_ack,
  // Master b, arbiter m0
  input  logic                  b_cyc,
  input  logic                  b_stb,
  input  logic                  b_we,
  input  scratchpad_pkg::addr_t b_adr,
  input  scratchpad_pkg::word_t b_dat_w,
  output scratchpad_pkg::word_t b_dat_r,
  output logic                  b_ack,
  // Master c, arbiter m1
  input  logic                  c_cyc,
  input  logic                  c_stb,
  input  logic                  c_we,
  input  scratchpad_pkg::addr_t c_adr,
  input  scratchpad_pkg::word_t c_dat_w,
  output scratchpad_pkg::word_t c_dat_r,
  output logic                  c_ack
);

  // RAM port 0, driven by master a
  logic                  port_0_access_enable;
  logic                  port_0_write;
  scratchpad_pkg::addr_t port_0_address;
  scratchpad_pkg::word_t port_0_write_data;
  scratchpad_pkg::word_t port_0_read_data;

  // RAM port 1, driven by the arbitrated pair
  logic                  port_1_access_enable;
  logic                  port_1_write;
  scratchpad_pkg::addr_t port_1_address;
  scratchpad_pkg::word_t port_1_write_data;
  scratchpad_pkg::word_t port_1_read_data;

  // Arbiter slave side
  logic                  s_cyc;
  logic                  s_stb;
  logic                  s_we;
  scratchpad_pkg::addr_t s_adr;
  scratchpad_pkg::word_t s_dat_w;
  scratchpad_pkg::word_t s_dat_r;
  logic                  s_ack;

  wb_ram_port u_port_a (
    .clock             (clock),
    .rst               (rst),
    .cyc               (a_cyc),
    .stb               (a_stb),
    .we                (a_we),
    .adr               (a_adr),
    .dat_w             (a_dat_w),
    .dat_r             (a_dat_r),
    .ack               (a_ack),
    .ram_access_enable (port_0_access_enable),
    .ram_write         (port_0_write),
    .ram_address       (port_0_address),
    .ram_write_data    (port_0_write_data),
    .ram_read_data     (port_0_read_data)
  );

  // b wins the first tie after reset
  wb_round_robin_arbiter u_arbiter (
    .clock    (clock),
    .rst      (rst),
    .m0_cyc   (b_cyc),
    .m0_stb   (b_stb),
    .m0_we    (b_we),
    .m0_adr   (b_adr),
    .m0_dat_w (b_dat_w),
    .m0_dat_r (b_dat_r),
    .m0_ack   (b_ack),
    .m1_cyc   (c_cyc),
    .m1_stb   (c_stb),
    .m1_we    (c_we),
    .m1_adr   (c_adr),
    .m1_dat_w (c_dat_w),
    .m1_dat_r (c_dat_r),
    .m1_ack   (c_ack),
    .s_cyc    (s_cyc),
    .s_stb    (s_stb),
    .s_we     (s_we),
    .s_adr    (s_adr),
    .s_dat_w  (s_dat_w),
    .s_dat_r  (s_dat_r),
    .s_ack    (s_ack)
  );

  wb_ram_port u_port_bc (
    .clock             (clock),
    .rst               (rst),
    .cyc               (s_cyc),
    .stb               (s_stb),
    .we                (s_we),
    .adr               (s_adr),
    .dat_w             (s_dat_w),
    .dat_r             (s_dat_r),
    .ack               (s_ack),
    .ram_access_enable (port_1_access_enable),
    .ram_write         (port_1_write),
    .ram_address       (port_1_address),
    .ram_write_data    (port_1_write_data),
    .ram_read_data     (port_1_read_data)
  );

  // Registered read gives the one-cycle ack latency
  true_dual_port_ram #(
    .WIDTH           (`SCRATCHPAD_DATA_WIDTH),
    .DEPTH           (`SCRATCHPAD_DEPTH),
    .WRITE_THROUGH   (`SCRATCHPAD_WRITE_THROUGH),
    .REGISTERED_READ (1'b1)
  ) u_ram (
    .clock                (clock),
    .port_0_access_enable (port_0_access_enable),
    .port_0_write         (port_0_write),
    .port_0_address       (port_0_address),
    .port_0_write_data    (port_0_write_data),
    .port_0_read_data     (port_0_read_data),
    .port_1_access_enable (port_1_access_enable),
    .port_1_write         (port_1_write),
    .port_1_address       (port_1_address),
    .port_1_write_data    (port_1_write_data),
    .port_1_read_data     (port_1_read_data)
  );

endmodule : shared_scratchpad

`default_nettype wire

//--- test/shared_scratchpad_checker.sv
// Bound into shared_scratchpad; reads arbiter state hierarchically; failure_count is read by the testbench
`timescale 1ns/1ps
`default_nettype none

module shared_scratchpad_checker (
  input logic                   clock,
  input logic                   rst,
  input logic                   a_cyc,
  input logic                   a_stb,
  input logic                   a_ack,
  input logic                   b_cyc,
  input logic                   b_stb,
  input logic                   b_ack,
  input logic                   c_cyc,
  input logic                   c_stb,
  input logic                   c_ack,
  input logic                   busy,
  input scratchpad_pkg::owner_t owner
);

  // Number of failed assertions so far
  int failure_count = 0;

  // Cycle line of the arbiter owner
  logic owner_cyc;
  assign owner_cyc = (owner == scratchpad_pkg::OWNER_M0) ? b_cyc : c_cyc;

  // Single-cycle ack pulses
  ack_pulse_a : assert property (@(posedge clock) disable iff (rst) a_ack |=> !a_ack)
    else begin failure_count++; $error("a_ack held for more than one cycle"); end
  ack_pulse_b : assert property (@(posedge clock) disable iff (rst) b_ack |=> !b_ack)
    else begin failure_count++; $error("b_ack held for more than one cycle"); end
  ack_pulse_c : assert property (@(posedge clock) disable iff (rst) c_ack |=> !c_ack)
    else begin failure_count++; $error("c_ack held for more than one cycle"); end

  // Ack only inside an active strobe
  ack_in_cycle : assert property (@(posedge clock) disable iff (rst)
      (a_ack |-> a_cyc && a_stb) and (b_ack |-> b_cyc && b_stb) and (c_ack |-> c_cyc && c_stb))
    else begin failure_count++; $error("ack outside of cyc and stb"); end

  // Shared port serves one master at a time
  acks_exclusive : assert property (@(posedge clock) disable iff (rst) !(b_ack && c_ack))
    else begin failure_count++; $error("b_ack and c_ack high together"); end

  // Grant is held while the owner keeps cyc
  owner_held : assert property (@(posedge clock) disable iff (rst)
      (busy && owner_cyc) |=> $stable(owner))
    else begin failure_count++; $error("arbiter owner changed during a cycle"); end

  // Fixed latency on port a
  a_latency : assert property (@(posedge clock) disable iff (rst)
      (a_cyc && a_stb && !a_ack) |=> a_ack)
    else begin failure_count++; $error("a_ack missing one cycle after request"); end

  // No ack coming out of reset
  quiet_in_reset : assert property (@(posedge clock) $past(rst) |-> !(a_ack || b_ack || c_ack))
    else begin failure_count++; $error("ack high during reset"); end

endmodule : shared_scratchpad_checker

bind shared_scratchpad shared_scratchpad_checker u_checker (
  .clock (clock), .rst (rst),
  .a_cyc (a_cyc), .a_stb (a_stb), .a_ack (a_ack),
  .b_cyc (b_cyc), .b_stb (b_stb), .b_ack (b_ack),
  .c_cyc (c_cyc), .c_stb (c_stb), .c_ack (c_ack),
  .busy  (u_arbiter.busy), .owner (u_arbiter.owner)
);

`default_nettype wire

//--- test/shared_scratchpad_tb.sv
// Masters indexed 0 to 2 for a, b, c; memory is only read at addresses written before
`timescale 1ns/1ps
`default_nettype none

module shared_scratchpad_tb;

  logic clock = 1'b0;
  logic rst;
  logic cyc [3];
  logic stb [3];
  logic we [3];
  scratchpad_pkg::addr_t adr [3];
  scratchpad_pkg::word_t dat_w [3];
  scratchpad_pkg::word_t a_dat_r;
  scratchpad_pkg::word_t b_dat_r;
  scratchpad_pkg::word_t c_dat_r;
  logic a_ack;
  logic b_ack;
  logic c_ack;

  // Reference memory and stimulus state
  scratchpad_pkg::word_t model [256];
  scratchpad_pkg::addr_t written [$];
  time done_time [3];
  int seed = 32'hf149f838;

  always #2 clock = ~clock;

  shared_scratchpad u_shared_scratchpad (
    .clock (clock), .rst (rst),
    .a_cyc (cyc[0]), .a_stb (stb[0]), .a_we (we[0]), .a_adr (adr[0]), .a_dat_w (dat_w[0]),
    .a_dat_r (a_dat_r), .a_ack (a_ack),
    .b_cyc (cyc[1]), .b_stb (stb[1]), .b_we (we[1]), .b_adr (adr[1]), .b_dat_w (dat_w[1]),
    .b_dat_r (b_dat_r), .b_ack (b_ack),
    .c_cyc (cyc[2]), .c_stb (stb[2]), .c_we (we[2]), .c_adr (adr[2]), .c_dat_w (dat_w[2]),
    .c_dat_r (c_dat_r), .c_ack (c_ack)
  );

  function automatic logic ack_of(input int m);
    return (m == 0) ? a_ack : (m == 1) ? b_ack : c_ack;
  endfunction

  function automatic scratchpad_pkg::word_t dat_r_of(input int m);
    return (m == 0) ? a_dat_r : (m == 1) ? b_dat_r : c_dat_r;
  endfunction

  function automatic string master_name(input int m);
    return (m == 0) ? "a" : (m == 1) ? "b" : "c";
  endfunction

  // One classic single-word cycle, ack sampled mid-cycle
  task automatic wb_access(input int m, input int delay, input logic write,
                           input scratchpad_pkg::addr_t address,
                           input scratchpad_pkg::word_t data,
                           output scratchpad_pkg::word_t rdata);
    int cycles;
    cycles = 0;
    repeat (delay) @(posedge clock);
    @(posedge clock);
    cyc[m] <= 1'b1;
    stb[m] <= 1'b1;
    we[m] <= write;
    adr[m] <= address;
    dat_w[m] <= data;
    @(negedge clock);
    while (!ack_of(m) && cycles < 50) begin
      @(negedge clock);
      cycles++;
    end
    if (!ack_of(m)) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "master %s timed out waiting for ack", master_name(m));
    end
    rdata = dat_r_of(m);
    done_time[m] = $time;
    @(posedge clock);
    cyc[m] <= 1'b0;
    stb[m] <= 1'b0;
    we[m] <= 1'b0;
  endtask

  task automatic check_read(input string signal, input scratchpad_pkg::word_t expected,
                            input scratchpad_pkg::word_t actual);
    assert (actual === expected) else begin
      $display("TESTBENCH FAILED");
      $display("** Error: %s expected %h got %h", signal, expected, actual);
      $fatal(1, "read data mismatch");
    end
  endtask

  // Stop at the first checker failure
  always @(negedge clock) begin
    if (u_shared_scratchpad.u_checker.failure_count != 0) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "protocol assertion failed in the checker");
    end
  end

  initial begin
    scratchpad_pkg::addr_t x;
    scratchpad_pkg::word_t wb;
    scratchpad_pkg::word_t wc;
    scratchpad_pkg::word_t rd;
    scratchpad_pkg::word_t rd_other;
    int last_bc;
    int winner;
    int loser;
    rst <= 1'b1;
    for (int m = 0; m < 3; m++) begin
      cyc[m] <= 1'b0;
      stb[m] <= 1'b0;
      we[m] <= 1'b0;
      adr[m] <= '0;
      dat_w[m] <= '0;
    end
    repeat (10) @(posedge clock);
    rst <= 1'b0;
    // Competing b and c, the master not served last wins each tie
    // After reset c counts as served last, so b wins the first tie
    last_bc = 2;
    for (int i = 0; i < 4; i++) begin
      // Odd rounds serve b alone first
      if (i % 2 == 1) begin
        wb = $random(seed);
        wb_access(1, 0, 1'b1, 8'(i), wb, rd);
        model[i] = wb;
        last_bc = 1;
      end
      wb = $random(seed);
      wc = $random(seed);
      winner = (last_bc == 1) ? 2 : 1;
      loser = 3 - winner;
      fork
        wb_access(1, 0, 1'b1, 8'(i), wb, rd);
        wb_access(2, 0, 1'b1, 8'(i + 4), wc, rd_other);
      join
      model[i] = wb;
      model[i + 4] = wc;
      assert (done_time[winner] < done_time[loser]) else begin
        $display("TESTBENCH FAILED");
        $fatal(1, "arbiter served %s before %s in round %0d", master_name(loser),
               master_name(winner), i);
      end
      last_bc = loser;
    end
    // Cycles with stb low must stay silent
    @(posedge clock);
    for (int m = 0; m < 3; m++) cyc[m] <= 1'b1;
    repeat (4) @(posedge clock);
    for (int m = 0; m < 3; m++) cyc[m] <= 1'b0;
    repeat (2) @(posedge clock);
    // Random traffic through the host port
    for (int i = 0; i < 16; i++) begin
      x = $random(seed);
      wb = $random(seed);
      wb_access(0, 0, 1'b1, x, wb, rd);
      model[x] = wb;
      written.push_back(x);
    end
    foreach (written[i]) begin
      wb_access(0, 0, 1'b0, written[i], '0, rd);
      check_read("a_dat_r", model[written[i]], rd);
    end
    // b to c, then c to a and b
    x = $random(seed);
    wb = $random(seed);
    wb_access(1, 0, 1'b1, x, wb, rd);
    model[x] = wb;
    wb_access(2, 0, 1'b0, x, '0, rd);
    check_read("c_dat_r", model[x], rd);
    x = x + 8'd1;
    wc = $random(seed);
    wb_access(2, 0, 1'b1, x, wc, rd);
    model[x] = wc;
    wb_access(0, 0, 1'b0, x, '0, rd);
    check_read("a_dat_r", model[x], rd);
    wb_access(1, 0, 1'b0, x, '0, rd);
    check_read("b_dat_r", model[x], rd);
    // Same-edge writes on both ports, port 1 keeps its word
    x = $random(seed);
    wb = $random(seed);
    wc = $random(seed);
    fork
      wb_access(0, 1, 1'b1, x, wc, rd);
      wb_access(1, 0, 1'b1, x, wb, rd_other);
    join
    model[x] = wb;
    wb_access(0, 0, 1'b0, x, '0, rd);
    check_read("a_dat_r", model[x], rd);
    // Read on a sees b's same-edge write
    wb = $random(seed);
    fork
      wb_access(0, 1, 1'b0, x, '0, rd);
      wb_access(1, 0, 1'b1, x, wb, rd_other);
    join
    model[x] = wb;
    check_read("a_dat_r", model[x], rd);
    repeat (4) @(posedge clock);
    if (u_shared_scratchpad.u_checker.failure_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : shared_scratchpad_tb

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/scratchpad_pkg.sv
verilog/true_dual_port_ram.sv
verilog/wb_ram_port.sv
verilog/wb_round_robin_arbiter.sv
verilog/shared_scratchpad.sv
test/shared_scratchpad_checker.sv
test/shared_scratchpad_tb.sv
